// File: include/boot_settings.svh
// Build-time sizes and addresses of the boot system, included by RTL and testbench sources
`ifndef BOOT_SETTINGS_SVH
`define BOOT_SETTINGS_SVH

// Bytes per memory line, one line is one 32-bit word
`define BOOT_LINE_BYTES 4

// Depth of the on-chip line memory in lines
`define BOOT_MEM_LINES 64

// Width of a core line address
`define BOOT_ADDR_BITS 10

// Clock cycles per UART bit, short so simulation stays quick
`define BOOT_CLKS_PER_BIT 8

// Line address of the UART transmit register, top of the line space
`define BOOT_UART_LINE 'h3FF

`endif

// File: rtl/BootTypes.sv
// Shared types of the boot system: memory line, bus requests, status and system state
`include "boot_settings.svh"

package BootTypes;

    // Address width of the line memory
    localparam int MemAddrBits = $clog2(`BOOT_MEM_LINES);

    // One memory line, filled as bytes by the loader and used as a word by the core
    // Byte 0 sits in the low 8 bits
    typedef union packed {
        logic [`BOOT_LINE_BYTES-1:0][7:0] bytes;
        logic [`BOOT_LINE_BYTES*8-1:0]    word;
    } lineWord_u;

    typedef logic [`BOOT_ADDR_BITS-1:0] lineAddr_t;

    typedef logic [MemAddrBits-1:0] memAddr_t;

    // Request on the core port
    typedef struct packed {
        lineAddr_t addr;
        logic      isWrite;
        lineWord_u writeValue;
    } busReq_t;

    // Request into the line memory
    typedef struct packed {
        memAddr_t  addr;
        logic      isWrite;
        lineWord_u writeValue;
    } memReq_t;

    typedef enum logic {
        StateLoad = 1'b0,
        StateRun  = 1'b1
    } sysState_e;

    typedef struct packed {
        sysState_e   state;
        logic        coreRst;
        logic [15:0] loadedBytes;
    } sysStatus_t;

endpackage

// File: rtl/UartReceiver.sv
// Serial receiver, turns 8N1 frames on rx into one byte strobe per frame
`timescale 1ns/1ns
`include "boot_settings.svh"

module UartReceiver (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx,
    output logic       byteValid,
    output logic [7:0] byteData
);
    localparam int ClksPerBit = `BOOT_CLKS_PER_BIT;
    localparam int HalfBit = ClksPerBit / 2;
    localparam int CountBits = $clog2(ClksPerBit);

    typedef enum logic [1:0] {
        RxIdle,
        RxStart,
        RxData,
        RxStop
    } rxState_e;

    rxState_e rxState;
    logic [CountBits-1:0] clkCount;
    logic [2:0] bitIndex;
    logic [7:0] shiftReg;

    // rx is sampled directly, its source runs from the same clock
    always_ff @(posedge clk) begin
        if (rst) begin
            rxState <= RxIdle;
            clkCount <= '0;
            bitIndex <= '0;
            byteValid <= 1'b0;
        end
        else begin
            byteValid <= 1'b0;
            case (rxState)
                RxIdle: begin
                    clkCount <= '0;
                    bitIndex <= '0;
                    if (!rx) begin
                        rxState <= RxStart;
                    end
                end
                RxStart: begin
                    // Check the start bit again at its middle, glitches go back to idle
                    if (clkCount == CountBits'(HalfBit - 1)) begin
                        clkCount <= '0;
                        rxState <= rx ? RxIdle : RxData;
                    end
                    else begin
                        clkCount <= clkCount + 1'b1;
                    end
                end
                RxData: begin
                    if (clkCount == CountBits'(ClksPerBit - 1)) begin
                        clkCount <= '0;
                        bitIndex <= bitIndex + 1'b1;
                        if (bitIndex == 3'd7) begin
                            rxState <= RxStop;
                        end
                    end
                    else begin
                        clkCount <= clkCount + 1'b1;
                    end
                end
                default: begin
                    // Middle of the stop bit, a low stop bit drops the frame
                    if (clkCount == CountBits'(ClksPerBit - 1)) begin
                        byteValid <= rx;
                        rxState <= RxIdle;
                    end
                    else begin
                        clkCount <= clkCount + 1'b1;
                    end
                end
            endcase
        end
    end

    // LSB first, so new bits enter at the top
    always_ff @(posedge clk) begin
        if (rxState == RxData && clkCount == CountBits'(ClksPerBit - 1)) begin
            shiftReg <= {rx, shiftReg[7:1]};
        end
        if (rxState == RxStop && clkCount == CountBits'(ClksPerBit - 1)) begin
            byteData <= shiftReg;
        end
    end

endmodule

// File: rtl/LineLoader.sv
// Packs received image bytes into memory lines and counts the bytes loaded so far
`timescale 1ns/1ns
`include "boot_settings.svh"

module LineLoader (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 byteValid,
    input  logic [7:0]           byteData,
    output logic                 lineValid,
    output BootTypes::lineWord_u lineData,
    output logic [15:0]          loadedBytes
);
    import BootTypes::*;

    localparam int LaneBits = $clog2(`BOOT_LINE_BYTES);

    lineWord_u holdLine;
    logic [LaneBits-1:0] lane;
    logic lastLane;

    // Byte lane follows the running count
    assign lane = loadedBytes[LaneBits-1:0];
    assign lastLane = (lane == LaneBits'(`BOOT_LINE_BYTES - 1));

    always_ff @(posedge clk) begin
        if (byteValid) begin
            holdLine.bytes[lane] <= byteData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lineValid <= 1'b0;
            loadedBytes <= '0;
        end
        else begin
            // Line is complete once the top lane has been written
            lineValid <= byteValid && lastLane;
            if (byteValid) begin
                loadedBytes <= loadedBytes + 16'd1;
            end
        end
    end

    // Finished line leaves as one word
    always_comb begin
        lineData.word = holdLine.word;
    end

endmodule

// File: rtl/LineMemory.sv
// On-chip line memory with a fixed two-cycle completion strobe per request
`timescale 1ns/1ns
`include "boot_settings.svh"

module LineMemory (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 memEnable,
    input  BootTypes::memReq_t   memReq,
    output logic                 memDone,
    output BootTypes::lineWord_u memReadValue
);
    import BootTypes::*;

    lineWord_u lines [`BOOT_MEM_LINES];

    logic accessValid;
    lineWord_u accessValue;

    // Access stage, one request per strobe
    always_ff @(posedge clk) begin
        if (memEnable) begin
            if (memReq.isWrite) begin
                lines[memReq.addr] <= memReq.writeValue;
            end
            accessValue <= lines[memReq.addr];
        end
    end

    // Reply stage
    always_ff @(posedge clk) begin
        if (accessValid) begin
            memReadValue <= accessValue;
        end
    end

    // Done strobe trails the request by two edges
    always_ff @(posedge clk) begin
        if (rst) begin
            accessValid <= 1'b0;
            memDone <= 1'b0;
        end
        else begin
            accessValid <= memEnable;
            memDone <= accessValid;
        end
    end

endmodule

// File: rtl/UartTransmitter.sv
// Serial transmitter, sends one byte per request as an 8N1 frame on tx
`timescale 1ns/1ns
`include "boot_settings.svh"

module UartTransmitter (
    input  logic       clk,
    input  logic       rst,
    input  logic       txValid,
    input  logic [7:0] txData,
    output logic       txReady,
    output logic       tx
);
    localparam int ClksPerBit = `BOOT_CLKS_PER_BIT;
    localparam int CountBits = $clog2(ClksPerBit);

    logic [CountBits-1:0] clkCount;
    logic [3:0] bitsLeft;
    logic [8:0] shiftReg;
    logic bitEnd;

    assign bitEnd = (clkCount == CountBits'(ClksPerBit - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            txReady <= 1'b1;
            tx <= 1'b1;
            clkCount <= '0;
            bitsLeft <= '0;
        end
        else if (txReady) begin
            // Start bit goes out on the same edge that takes the byte
            if (txValid) begin
                txReady <= 1'b0;
                tx <= 1'b0;
                clkCount <= '0;
                bitsLeft <= 4'd9;
            end
        end
        else if (bitEnd) begin
            clkCount <= '0;
            if (bitsLeft == 4'd0) begin
                txReady <= 1'b1;
            end
            else begin
                tx <= shiftReg[0];
                bitsLeft <= bitsLeft - 4'd1;
            end
        end
        else begin
            clkCount <= clkCount + 1'b1;
        end
    end

    // Data bits then the stop bit, the start bit is driven directly
    always_ff @(posedge clk) begin
        if (txReady && txValid) begin
            shiftReg <= {1'b1, txData};
        end
        else if (!txReady && bitEnd && bitsLeft != 4'd0) begin
            shiftReg <= {1'b1, shiftReg[8:1]};
        end
    end

endmodule

// File: rtl/BootSystem.sv
// Top of the boot system, loads the image over UART then serves core line requests
`timescale 1ns/1ns
`include "boot_settings.svh"

module BootSystem (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rx,
    output logic                  tx,
    input  logic [15:0]           loadSize,
    input  logic                  coreEnable,
    input  BootTypes::busReq_t    coreReq,
    output logic                  coreDone,
    output BootTypes::lineWord_u  coreReadValue,
    output logic                  txReady,
    output BootTypes::sysStatus_t status
);
    import BootTypes::*;

    localparam int LaneBits = $clog2(`BOOT_LINE_BYTES);

    sysState_e state;
    logic coreRst;

    logic byteValid;
    logic [7:0] byteData;
    logic lineValid;
    lineWord_u lineData;
    logic [15:0] loadedBytes;
    logic [15:0] lastByteIndex;

    logic memEnable;
    memReq_t memReq;
    logic memDone;
    lineWord_u memReadValue;

    logic txValid;
    logic [7:0] txData;

    logic inMemRange;
    logic isUartLine;
    logic quickDone;
    logic coreMemPending;
    logic coreMemDone;

    UartReceiver m_UartReceiver (
        .clk,
        .rst,
        .rx,
        .byteValid,
        .byteData
    );

    LineLoader m_LineLoader (
        .clk,
        .rst,
        .byteValid,
        .byteData,
        .lineValid,
        .lineData,
        .loadedBytes
    );

    LineMemory m_LineMemory (
        .clk,
        .rst,
        .memEnable,
        .memReq,
        .memDone,
        .memReadValue
    );

    UartTransmitter m_UartTransmitter (
        .clk,
        .rst,
        .txValid,
        .txData,
        .txReady,
        .tx
    );

    // Address decode of the core line address
    assign inMemRange = (coreReq.addr < lineAddr_t'(`BOOT_MEM_LINES));
    assign isUartLine = (coreReq.addr == lineAddr_t'(`BOOT_UART_LINE));

    // Count has already moved past the last byte of the line
    assign lastByteIndex = loadedBytes - 16'd1;

    // Memory source follows the state
    always_comb begin
        if (state == StateLoad) begin
            memEnable = lineValid;
            memReq.addr = lastByteIndex[LaneBits +: MemAddrBits];
            memReq.isWrite = 1'b1;
            memReq.writeValue = lineData;
        end
        else begin
            memEnable = coreEnable && inMemRange;
            memReq.addr = coreReq.addr[MemAddrBits-1:0];
            memReq.isWrite = coreReq.isWrite;
            memReq.writeValue = coreReq.writeValue;
        end
    end

    // Writes while the transmitter is busy are lost but still completed
    assign txValid = (state == StateRun) && coreEnable && isUartLine && coreReq.isWrite
                     && txReady;
    assign txData = coreReq.writeValue.bytes[0];

    // Only memory replies owed to the core count, the last load write may land in run
    assign coreMemDone = memDone && coreMemPending;
    assign coreDone = quickDone || coreMemDone;
    assign coreReadValue = coreMemDone ? memReadValue : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= StateLoad;
            coreRst <= 1'b1;
            quickDone <= 1'b0;
            coreMemPending <= 1'b0;
        end
        else begin
            if (state == StateLoad && loadedBytes >= loadSize) begin
                state <= StateRun;
            end
            // Core leaves reset one cycle into run
            if (state == StateRun) begin
                coreRst <= 1'b0;
            end
            // UART line and unmapped lines complete at once
            quickDone <= (state == StateRun) && coreEnable && !inMemRange;
            if (state == StateRun && memEnable) begin
                coreMemPending <= 1'b1;
            end
            else if (memDone) begin
                coreMemPending <= 1'b0;
            end
        end
    end

    always_comb begin
        status.state = state;
        status.coreRst = coreRst;
        status.loadedBytes = loadedBytes;
    end

endmodule

// File: sim/BootSystemChecker.sv
// Testbench checker, watches the boot system ports, models memory and serial output, counts errors
`timescale 1ns/1ns
`include "boot_settings.svh"

module BootSystemChecker #(
    parameter int LoadBytes = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [LoadBytes*8-1:0] loadImage,
    input  logic                   tx,
    input  logic                   coreEnable,
    input  BootTypes::busReq_t     coreReq,
    input  logic                   coreDone,
    input  BootTypes::lineWord_u   coreReadValue,
    input  logic                   txReady,
    input  BootTypes::sysStatus_t  status,
    output int                     errorCount,
    output int                     framesOwed
);
    import BootTypes::*;

    localparam int ClksPerBit = `BOOT_CLKS_PER_BIT;
    localparam int MaxFrames = 16;

    lineWord_u modelMem [`BOOT_MEM_LINES];
    logic [7:0] expectBytes [MaxFrames];
    busReq_t pendReq;
    logic pendValid;
    sysState_e prevState;
    logic [15:0] prevLoaded;
    int cycle;
    int reqCycle;
    int runCycles;
    int replyErrors;
    int frameErrors;
    int framesExpected;
    int framesSeen;
    int txBusyLeft;

    assign errorCount = replyErrors + frameErrors;
    assign framesOwed = framesExpected - framesSeen;

    // Everything is sampled on the falling edge, halfway between DUT updates
    always @(negedge clk) begin
        int expectDelay;
        logic inMem;
        logic expectReady;
        lineWord_u expectValue;
        if (rst) begin
            pendValid = 1'b0;
            prevState = StateLoad;
            prevLoaded = '0;
            runCycles = 0;
            txBusyLeft = 0;
        end
        else begin
            // Transmitter stays busy for one whole frame after an accepted write
            expectReady = (txBusyLeft == 0);
            if (txReady !== expectReady) begin
                $display("ERR txReady: got 0x%01h expected 0x%01h", txReady, expectReady);
                replyErrors++;
            end
            if (txBusyLeft > 0) begin
                txBusyLeft--;
            end

            if (status.state == StateLoad) begin
                if (!status.coreRst) begin
                    $display("Core left reset while the image was still loading");
                    replyErrors++;
                end
                if (prevLoaded >= 16'(LoadBytes)) begin
                    $display("State stayed in load after the image was complete");
                    replyErrors++;
                end
                if (prevState == StateRun) begin
                    $display("State went back from run to load");
                    replyErrors++;
                end
            end
            else begin
                if (prevState == StateLoad) begin
                    if (status.loadedBytes !== 16'(LoadBytes)) begin
                        $display("ERR status.loadedBytes: got 0x%04h expected 0x%04h",
                                 status.loadedBytes, 16'(LoadBytes));
                        replyErrors++;
                    end
                    // Image bytes land little-endian, byte 0 in the low bits of line 0
                    for (int k = 0; k < LoadBytes / 4; k++) begin
                        modelMem[k].word = loadImage[32*k +: 32];
                    end
                end
                // Core reset drops exactly one cycle into run
                if (runCycles == 0 && !status.coreRst) begin
                    $display("Core reset fell together with the state change");
                    replyErrors++;
                end
                if (runCycles >= 1 && status.coreRst) begin
                    $display("Core reset still high %0d cycles into run", runCycles);
                    replyErrors++;
                end
                runCycles++;
            end

            if (pendValid && coreDone) begin
                inMem = (pendReq.addr < lineAddr_t'(`BOOT_MEM_LINES));
                expectDelay = inMem ? 2 : 1;
                if (cycle - reqCycle != expectDelay) begin
                    $display("coreDone came %0d cycles after coreEnable instead of %0d",
                             cycle - reqCycle, expectDelay);
                    replyErrors++;
                end
                // Non-memory lines always answer zero, writes included
                if (!pendReq.isWrite || !inMem) begin
                    expectValue.word = inMem ? modelMem[pendReq.addr[MemAddrBits-1:0]].word
                                             : 32'h0;
                    if (coreReadValue.word !== expectValue.word) begin
                        $display("ERR coreReadValue line 0x%03h: got 0x%08h expected 0x%08h",
                                 pendReq.addr, coreReadValue.word, expectValue.word);
                        replyErrors++;
                    end
                end
                if (pendReq.isWrite && inMem) begin
                    modelMem[pendReq.addr[MemAddrBits-1:0]] = pendReq.writeValue;
                end
                pendValid = 1'b0;
            end
            else if (pendValid && cycle - reqCycle > 2) begin
                $display("No coreDone for the request to line 0x%03h", pendReq.addr);
                replyErrors++;
                pendValid = 1'b0;
            end
            else if (!pendValid && coreDone) begin
                $display("coreDone seen without an open request");
                replyErrors++;
            end

            if (coreEnable && status.state == StateRun) begin
                if (pendValid) begin
                    $display("New request issued while another one was open");
                    replyErrors++;
                end
                pendReq = coreReq;
                pendValid = 1'b1;
                reqCycle = cycle;
                // A write to the UART line while the transmitter is busy is dropped
                if (coreReq.isWrite && coreReq.addr == lineAddr_t'(`BOOT_UART_LINE)
                    && txBusyLeft == 0) begin
                    if (framesExpected < MaxFrames) begin
                        expectBytes[framesExpected] = coreReq.writeValue.bytes[0];
                        framesExpected++;
                    end
                    txBusyLeft = 10 * ClksPerBit;
                end
            end
            prevState = status.state;
            prevLoaded = status.loadedBytes;
        end
        cycle++;
    end

    // Serial decoder, samples each bit near its middle
    always begin
        logic [7:0] rxByte;
        int bitIdx;
        @(negedge clk);
        if (!rst && tx === 1'b0) begin
            repeat (ClksPerBit / 2) @(negedge clk);
            for (bitIdx = 0; bitIdx < 8; bitIdx++) begin
                repeat (ClksPerBit) @(negedge clk);
                rxByte[bitIdx] = tx;
            end
            repeat (ClksPerBit) @(negedge clk);
            if (tx !== 1'b1) begin
                $display("Serial frame on tx ended without a stop bit");
                frameErrors++;
            end
            else if (framesSeen >= framesExpected) begin
                $display("Serial frame 0x%02h sent without a UART write", rxByte);
                frameErrors++;
            end
            else if (rxByte !== expectBytes[framesSeen]) begin
                $display("ERR tx byte: got 0x%02h expected 0x%02h",
                         rxByte, expectBytes[framesSeen]);
                frameErrors++;
            end
            if (framesSeen < framesExpected) begin
                framesSeen++;
            end
        end
    end

endmodule

// File: sim/BootSystemTb.sv
// Testbench top, loads an image over the serial line and then runs a table of core requests
`timescale 1ns/1ns
`include "boot_settings.svh"

module BootSystemTb;
    import BootTypes::*;

    localparam int LoadBytes = 16;
    localparam int NumOps = 17;
    localparam int ResetCycles = 10;
    localparam int ClksPerBit = `BOOT_CLKS_PER_BIT;
    localparam int LoadCycles = LoadBytes * 10 * ClksPerBit;
    localparam int WatchdogCycles = ResetCycles + LoadCycles + 200 * NumOps;

    // One core request: line, write flag, random data flag, table data
    typedef struct packed {
        lineAddr_t   addr;
        logic        isWrite;
        logic        useRandom;
        logic [31:0] value;
    } coreOp_t;

    logic clk = 1'b0;
    logic rst;
    logic rx;
    logic tx;
    logic [15:0] loadSize;
    logic coreEnable;
    busReq_t coreReq;
    logic coreDone;
    lineWord_u coreReadValue;
    logic txReady;
    sysStatus_t status;

    logic [7:0] loadTable [LoadBytes];
    logic [LoadBytes*8-1:0] loadImage;
    coreOp_t opTable [NumOps];
    logic [15:0] lfsrState;
    int driverErrors;
    int checkErrors;
    int framesOwed;

    always #4 clk = ~clk;

    BootSystem BootSystem_i (
        .clk,
        .rst,
        .rx,
        .tx,
        .loadSize,
        .coreEnable,
        .coreReq,
        .coreDone,
        .coreReadValue,
        .txReady,
        .status
    );

    BootSystemChecker #(.LoadBytes(LoadBytes)) replyCheck (
        .clk,
        .rst,
        .loadImage,
        .tx,
        .coreEnable,
        .coreReq,
        .coreDone,
        .coreReadValue,
        .txReady,
        .status,
        .errorCount(checkErrors),
        .framesOwed
    );

    task automatic fillTables();
        for (int i = 0; i < LoadBytes; i++) begin
            loadTable[i] = 8'h11 * i[7:0] + 8'h3C;
            loadImage[8*i +: 8] = loadTable[i];
        end
        // Lines 0 to 3 hold the image, then random round trips
        opTable[0]  = {10'h000, 1'b0, 1'b0, 32'h0};
        opTable[1]  = {10'h001, 1'b0, 1'b0, 32'h0};
        opTable[2]  = {10'h002, 1'b0, 1'b0, 32'h0};
        opTable[3]  = {10'h003, 1'b0, 1'b0, 32'h0};
        opTable[4]  = {10'h005, 1'b1, 1'b1, 32'h0};
        opTable[5]  = {10'h005, 1'b0, 1'b0, 32'h0};
        opTable[6]  = {10'h00A, 1'b1, 1'b1, 32'h0};
        opTable[7]  = {10'h03F, 1'b1, 1'b1, 32'h0};
        opTable[8]  = {10'h00A, 1'b0, 1'b0, 32'h0};
        opTable[9]  = {10'h03F, 1'b0, 1'b0, 32'h0};
        // Two UART writes, the second waits for the first frame to finish
        opTable[10] = {10'h3FF, 1'b1, 1'b0, 32'h1234_56A5};
        opTable[11] = {10'h3FF, 1'b1, 1'b1, 32'h0};
        // Unmapped lines, 0x040 would alias line 0 if the decode were wrong
        opTable[12] = {10'h200, 1'b0, 1'b0, 32'h0};
        opTable[13] = {10'h040, 1'b1, 1'b0, 32'hDEAD_BEEF};
        opTable[14] = {10'h000, 1'b0, 1'b0, 32'h0};
        opTable[15] = {10'h3FF, 1'b0, 1'b0, 32'h0};
        opTable[16] = {10'h005, 1'b0, 1'b0, 32'h0};
    endtask

    function automatic logic [15:0] lfsrNext(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic drawRandomWord(output logic [31:0] word);
        word = '0;
        for (int i = 0; i < 32; i++) begin
            word = {lfsrState[0], word[31:1]};
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    // Called right after a rising edge, one frame of ten bits
    task automatic sendByte(input logic [7:0] value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx <= frame[i];
            repeat (ClksPerBit) @(posedge clk);
        end
    endtask

    task automatic waitForRun();
        int waitCycles;
        waitCycles = 0;
        @(negedge clk);
        while (!(status.state == StateRun && !status.coreRst) && waitCycles < 50) begin
            @(negedge clk);
            waitCycles++;
        end
        if (status.state != StateRun || status.coreRst) begin
            $display("System did not reach run with the core out of reset after the load");
            driverErrors++;
        end
    endtask

    task automatic runOp(input coreOp_t op);
        logic [31:0] data;
        busReq_t req;
        int waitCycles;
        data = op.value;
        if (op.useRandom) begin
            drawRandomWord(data);
        end
        if (op.isWrite && op.addr == lineAddr_t'(`BOOT_UART_LINE)) begin
            waitCycles = 0;
            @(negedge clk);
            while (!txReady && waitCycles < 15 * ClksPerBit) begin
                @(negedge clk);
                waitCycles++;
            end
            if (!txReady) begin
                $display("Transmitter never became ready for the UART write");
                driverErrors++;
            end
        end
        req.addr = op.addr;
        req.isWrite = op.isWrite;
        req.writeValue.word = data;
        @(posedge clk);
        coreEnable <= 1'b1;
        coreReq <= req;
        @(posedge clk);
        coreEnable <= 1'b0;
        waitCycles = 0;
        @(negedge clk);
        while (!coreDone && waitCycles < 20) begin
            @(negedge clk);
            waitCycles++;
        end
        if (!coreDone) begin
            $display("Request to line 0x%03h never completed", op.addr);
            driverErrors++;
        end
    endtask

    // Let the last frame leave the transmitter before counting frames
    task automatic drainSerial();
        int waitCycles;
        waitCycles = 0;
        @(negedge clk);
        while (!txReady && waitCycles < 15 * ClksPerBit) begin
            @(negedge clk);
            waitCycles++;
        end
        repeat (2 * ClksPerBit) @(negedge clk);
        if (framesOwed != 0) begin
            $display("%0d serial frames were expected on tx but never seen", framesOwed);
            driverErrors++;
        end
    endtask

    initial begin
        int idx;
        rst = 1'b1;
        rx = 1'b1;
        loadSize = 16'(LoadBytes);
        coreEnable = 1'b0;
        coreReq = '0;
        lfsrState = 16'd48474;
        driverErrors = 0;
        fillTables();
        repeat (ResetCycles) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        for (idx = 0; idx < LoadBytes; idx++) begin
            sendByte(loadTable[idx]);
        end
        waitForRun();
        for (idx = 0; idx < NumOps; idx++) begin
            runOp(opTable[idx]);
        end
        drainSerial();
        $display("Run finished with %0d checker errors and %0d driver errors",
                 checkErrors, driverErrors);
        if (checkErrors + driverErrors == 0) begin
            $display("NO ERRORS");
        end
        else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Watchdog sized from the load time plus a budget per request
    initial begin
        repeat (WatchdogCycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the run finished", WatchdogCycles);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
rtl/BootTypes.sv
rtl/UartReceiver.sv
rtl/LineLoader.sv
rtl/LineMemory.sv
rtl/UartTransmitter.sv
rtl/BootSystem.sv
sim/BootSystemChecker.sv
sim/BootSystemTb.sv

// File: Bender.yml
package:
  name: boot_system

sources:
  - include_dirs:
      - include
    files:
      - rtl/BootTypes.sv
      - rtl/UartReceiver.sv
      - rtl/LineLoader.sv
      - rtl/LineMemory.sv
      - rtl/UartTransmitter.sv
      - rtl/BootSystem.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/BootSystemChecker.sv
      - sim/BootSystemTb.sv
